// ==== Bender.yml ====
package:
  name: l2tlb

sources:
  - files:
      - source/sv32_pkg.sv
      - source/tlb_pkg.sv
      - source/l1_req_arbiter.sv
      - source/tlb_cache.sv
      - source/page_walker.sv
      - source/resp_router.sv
      - source/l2tlb.sv
  - target: test
    files:
      - bench/l2tlb_props.sv
      - bench/l2tlb_tb.sv

// ==== bench/l2tlb_props.sv ====
`timescale 1ns/10ps

module l2tlb_props import sv32_pkg::*; (
    input logic   clk,
    input logic   rst_i,
    input logic   itlb_ready_i,
    input logic   dtlb_ready_i,
    input logic   flush_i,
    input logic   flush_done_i,
    input logic   mem_req_i,
    input logic   mem_rvalid_i,
    input paddr_t mem_addr_i
);

    int   assert_fails = 0;
    logic fence_open_q;

    // open from the edge that sees flush_i until the one after flush_done.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            fence_open_q <= 1'b0;
        end else if (flush_i) begin
            fence_open_q <= 1'b1;
        end else if (flush_done_i) begin
            fence_open_q <= 1'b0;
        end
    end

    mem_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_i && !mem_rvalid_i |=> $stable(mem_addr_i))
    else begin
        $error("mem_addr_o moved during an outstanding read");
        assert_fails++;
    end

    readys_low_in_fence: assert property (@(posedge clk) disable iff (rst_i)
        fence_open_q |-> !itlb_ready_i && !dtlb_ready_i)
    else begin
        $error("a ready output was high during a fence");
        assert_fails++;
    end

    flush_completes: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |-> ##[1:16] flush_done_i)
    else begin
        $error("flush_done_o did not follow flush_i");
        assert_fails++;
    end

endmodule

bind l2tlb l2tlb_props u_props (
    .clk          (clk),
    .rst_i        (rst_i),
    .itlb_ready_i (itlb_ready_o),
    .dtlb_ready_i (dtlb_ready_o),
    .flush_i      (flush_i),
    .flush_done_i (flush_done_o),
    .mem_req_i    (mem_req_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_addr_i   (mem_addr_o)
);

// ==== bench/l2tlb_tb.sv ====
`timescale 1ns/10ps

module l2tlb_tb import sv32_pkg::*, tlb_pkg::*; ();

    localparam int   TIMEOUT  = 200;
    localparam ppn_t ROOT_PPN = 22'h00100;

    logic      clk = 1'b0;
    logic      rst_i;
    logic      itlb_valid_i;
    tlb_req_t  itlb_req_i;
    logic      dtlb_valid_i;
    tlb_req_t  dtlb_req_i;
    ppn_t      satp_ppn_i;
    logic      flush_i;
    logic      mem_rvalid_i;
    pte_t      mem_rdata_i;
    logic      itlb_ready_o;
    logic      dtlb_ready_o;
    logic      itlb_resp_valid_o;
    tlb_resp_t itlb_resp_o;
    logic      dtlb_resp_valid_o;
    tlb_resp_t dtlb_resp_o;
    logic      flush_done_o;
    logic      mem_req_o;
    paddr_t    mem_addr_o;

    // sparse page-table memory where absent entries read as zero.
    pte_t      pt_mem [paddr_t];
    tlb_resp_t want_resp [2][8];
    logic      pending [2][8];
    int        mem_reads;

    l2tlb u_dut (.*);

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic pte_t read_pte(paddr_t addr);
        if (pt_mem.exists(addr)) begin
            return pt_mem[addr];
        end
        return '0;
    endfunction

    function automatic paddr_t entry_addr(ppn_t table_ppn, int idx);
        return {table_ppn, 12'h000} + paddr_t'(idx * PTE_BYTES);
    endfunction

    function automatic pte_t make_pte(ppn_t ppn, pte_flags_t flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic pte_flags_t leaf_flags();
        return (pte_flags_t'($urandom) & 8'hfc) | 8'h03;
    endfunction

    // two-level walk; ppn and flags only mean something without a fault.
    function automatic tlb_resp_t model_walk(vpn_t vpn, tag_t tag, src_t src);
        tlb_resp_t r;
        pte_t      pte;
        r     = '0;
        r.vpn = vpn;
        r.tag = tag;
        r.src = src;
        pte   = read_pte(entry_addr(ROOT_PPN, vpn[19:10]));
        if (pte[PTE_V] && (pte[PTE_R] || pte[PTE_X])) begin
            r.fault     = (pte[19:10] != 10'h0);
            r.superpage = 1'b1;
            r.flags     = pte[7:0];
            r.ppn       = {pte[31:20], vpn[9:0]};
        end else if (!pte[PTE_V]) begin
            r.fault = 1'b1;
        end else begin
            pte     = read_pte(entry_addr(pte[31:10], vpn[9:0]));
            r.fault = !pte[PTE_V] || !(pte[PTE_R] || pte[PTE_X]);
            r.flags = pte[7:0];
            r.ppn   = pte[31:10];
        end
        return r;
    endfunction

    // one level-1 slot of each kind in a random order.
    function automatic void fill_tables();
        int     base;
        int     kind;
        paddr_t slot;
        ppn_t   table_ppn;
        base = $urandom % 4;
        pt_mem.delete();
        for (int hi = 0; hi < 4; hi++) begin
            slot = entry_addr(ROOT_PPN, hi);
            kind = (hi + base) % 4;
            if (kind == 1) begin
                pt_mem[slot] = make_pte({12'($urandom), 10'h0}, leaf_flags());
            end else if (kind == 2) begin
                pt_mem[slot] = make_pte({12'($urandom), 10'(1 + $urandom % 1023)},
                                        leaf_flags());
            end else if (kind == 3) begin
                table_ppn    = 22'h200 + 22'(hi);
                pt_mem[slot] = make_pte(table_ppn, 8'h01);
                for (int lo = 0; lo < 8; lo++) begin
                    kind = $urandom % 4;
                    slot = entry_addr(table_ppn, lo);
                    if (kind == 1) begin
                        pt_mem[slot] = make_pte(22'($urandom), 8'h01);
                    end else if (kind >= 2) begin
                        pt_mem[slot] = make_pte(22'($urandom), leaf_flags());
                    end
                end
            end
        end
    endfunction

    function automatic int open_count();
        int n;
        n = 0;
        for (int s = 0; s < 2; s++) begin
            for (int t = 0; t < 8; t++) begin
                n += pending[s][t];
            end
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            stop_failed($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    task automatic check_resp(input src_t port, input tlb_resp_t got);
        tlb_resp_t want;
        string     name;
        name = (port == SRC_ITLB) ? "itlb_resp_o" : "dtlb_resp_o";
        if (!pending[port][got.tag]) begin
            stop_failed($sformatf("%s carried tag %0d with no open request", name, got.tag));
        end
        want = want_resp[port][got.tag];
        pending[port][got.tag] = 1'b0;
        check_value({name, ".src"}, got.src, want.src);
        check_value({name, ".vpn"}, got.vpn, want.vpn);
        check_value({name, ".fault"}, got.fault, want.fault);
        if (!want.fault) begin
            check_value({name, ".ppn"}, got.ppn, want.ppn);
            check_value({name, ".flags"}, got.flags, want.flags);
            check_value({name, ".superpage"}, got.superpage, want.superpage);
        end
    endtask

    always begin : resp_monitor
        @(negedge clk);
        if (u_dut.u_props.assert_fails != 0) begin
            stop_failed("a bound assertion on the DUT ports failed");
        end
        if (!rst_i && itlb_resp_valid_o) begin
            check_resp(SRC_ITLB, itlb_resp_o);
        end
        if (!rst_i && dtlb_resp_valid_o) begin
            check_resp(SRC_DTLB, dtlb_resp_o);
        end
    end

    // answers each read after 1 to 6 cycles.
    always begin : mem_model
        paddr_t addr;
        int     delay;
        @(negedge clk);
        if (!rst_i && mem_req_o) begin
            addr  = mem_addr_o;
            delay = 1 + ($urandom % 6);
            repeat (delay) @(posedge clk);
            #1;
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = read_pte(addr);
            mem_reads++;
            @(posedge clk);
            #1;
            mem_rvalid_i = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send(input src_t port, input vpn_t vpn, input tag_t tag);
        tlb_req_t req;
        logic     ready;
        int       cycles;
        req.vpn = vpn;
        req.tag = tag;
        ready   = 1'b0;
        cycles  = 0;
        if (port == SRC_ITLB) begin
            itlb_req_i   = req;
            itlb_valid_i = 1'b1;
        end else begin
            dtlb_req_i   = req;
            dtlb_valid_i = 1'b1;
        end
        while (!ready) begin
            @(negedge clk);
            ready = (port == SRC_ITLB) ? itlb_ready_o : dtlb_ready_o;
            cycles++;
            if (!ready && cycles > TIMEOUT) begin
                stop_failed("a request was never accepted");
            end
        end
        want_resp[port][tag] = model_walk(vpn, tag, port);
        pending[port][tag]   = 1'b1;
        @(posedge clk);
        #1;
        if (port == SRC_ITLB) begin
            itlb_valid_i = 1'b0;
        end else begin
            dtlb_valid_i = 1'b0;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (open_count() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_failed("a request got no response in time");
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_fence();
        logic done;
        int   cycles;
        done   = 1'b0;
        cycles = 0;
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = flush_done_o;
            cycles++;
            if (!done && cycles > TIMEOUT) begin
                stop_failed("flush_done_o never followed flush_i");
            end
        end
        @(posedge clk);
        #1;
    endtask

    // every page twice; the repeat hits unless the page faults.
    task automatic sweep_pages(input bit backward);
        vpn_t      vpn;
        tlb_resp_t want;
        int        reads;
        for (int hi = 0; hi < 4; hi++) begin
            for (int lo = 0; lo < 8; lo++) begin
                vpn  = backward ? {10'(3 - hi), 10'(7 - lo)} : {10'(hi), 10'(lo)};
                want = model_walk(vpn, 3'd0, SRC_ITLB);
                send(src_t'($urandom % 2), vpn, 3'(lo));
                wait_idle();
                reads = mem_reads;
                send(src_t'($urandom % 2), vpn, 3'(lo));
                wait_idle();
                if (want.fault && mem_reads == reads) begin
                    stop_failed("a faulting page was answered without a new walk");
                end else if (!want.fault) begin
                    check_value("mem_req_o reads for a cached page", mem_reads, reads);
                end
            end
        end
    endtask

    task automatic port_traffic(input src_t port, input int count);
        tag_t tag;
        int   cycles;
        for (int k = 0; k < count; k++) begin
            tag    = tag_t'(k);
            cycles = 0;
            while (pending[port][tag]) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > TIMEOUT) begin
                    stop_failed("a tag stayed open without a response");
                end
            end
            send(port, {10'($urandom % 4), 10'($urandom % 8)}, tag);
            idle_cycles($urandom % 3);
        end
    endtask

    initial begin
        void'($urandom(40961));
        rst_i        = 1'b1;
        itlb_valid_i = 1'b0;
        itlb_req_i   = '0;
        dtlb_valid_i = 1'b0;
        dtlb_req_i   = '0;
        satp_ppn_i   = ROOT_PPN;
        flush_i      = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_reads    = 0;
        for (int s = 0; s < 2; s++) begin
            for (int t = 0; t < 8; t++) begin
                pending[s][t] = 1'b0;
            end
        end
        fill_tables();
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(negedge clk);
        check_value("itlb_ready_o", itlb_ready_o, 1);
        check_value("dtlb_ready_o", dtlb_ready_o, 1);
        check_value("itlb_resp_valid_o", itlb_resp_valid_o, 0);
        check_value("dtlb_resp_valid_o", dtlb_resp_valid_o, 0);
        check_value("mem_req_o", mem_req_o, 0);
        check_value("flush_done_o", flush_done_o, 0);
        @(posedge clk);
        #1;
        sweep_pages(1'b0);
        // new mappings after the fence must replace the cached ones.
        run_fence();
        fill_tables();
        // the pages cached last are asked for first.
        sweep_pages(1'b1);
        fork
            port_traffic(SRC_ITLB, 60);
            port_traffic(SRC_DTLB, 60);
        join
        wait_idle();
        run_fence();
        if (u_dut.u_props.assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            stop_failed("a bound assertion on the DUT ports failed");
        end
        $finish;
    end

endmodule

// ==== l2tlb.f ====
source/sv32_pkg.sv
source/tlb_pkg.sv
source/l1_req_arbiter.sv
source/tlb_cache.sv
source/page_walker.sv
source/resp_router.sv
source/l2tlb.sv
bench/l2tlb_props.sv
bench/l2tlb_tb.sv

// ==== source/l1_req_arbiter.sv ====
`timescale 1ns/10ps

module l1_req_arbiter import tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        itlb_valid_i,
    input  tlb_req_t    itlb_req_i,
    input  logic        dtlb_valid_i,
    input  tlb_req_t    dtlb_req_i,
    input  logic        lookup_ready_i,
    input  logic        refill_valid_i,
    input  logic        flush_i,
    input  logic        flush_done_i,
    output logic        itlb_ready_o,
    output logic        dtlb_ready_o,
    output logic        lookup_valid_o,
    output tlb_lookup_t lookup_o
);

    logic rr_dtlb_q;
    logic fence_q;
    logic pick_itlb;
    logic pick_dtlb;
    logic blocked;

    // rr_dtlb_q set means dtlb wins a tie.
    assign pick_dtlb = dtlb_valid_i & (~itlb_valid_i | rr_dtlb_q);
    assign pick_itlb = itlb_valid_i & (~dtlb_valid_i | ~rr_dtlb_q);

    // no new lookups during a fence or while the walker writes back.
    assign blocked = fence_q | refill_valid_i;

    assign itlb_ready_o = lookup_ready_i & ~blocked & ~pick_dtlb;
    assign dtlb_ready_o = lookup_ready_i & ~blocked & ~pick_itlb;

    assign lookup_valid_o = (itlb_valid_i | dtlb_valid_i) & ~blocked;

    always_comb begin
        if (pick_dtlb) begin
            lookup_o.vpn = dtlb_req_i.vpn;
            lookup_o.tag = dtlb_req_i.tag;
            lookup_o.src = SRC_DTLB;
        end else begin
            lookup_o.vpn = itlb_req_i.vpn;
            lookup_o.tag = itlb_req_i.tag;
            lookup_o.src = SRC_ITLB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rr_dtlb_q <= 1'b0;
            fence_q   <= 1'b0;
        end else begin
            // the port just served loses the next tie.
            if (lookup_valid_o && lookup_ready_i) begin
                rr_dtlb_q <= (lookup_o.src == SRC_ITLB);
            end
            if (flush_done_i) begin
                fence_q <= 1'b0;
            end
            if (flush_i) begin
                fence_q <= 1'b1;
            end
        end
    end

endmodule

// ==== source/l2tlb.sv ====
`timescale 1ns/10ps

module l2tlb import sv32_pkg::*, tlb_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      itlb_valid_i,
    input  tlb_req_t  itlb_req_i,
    input  logic      dtlb_valid_i,
    input  tlb_req_t  dtlb_req_i,
    input  ppn_t      satp_ppn_i,
    input  logic      flush_i,
    input  logic      mem_rvalid_i,
    input  pte_t      mem_rdata_i,
    output logic      itlb_ready_o,
    output logic      dtlb_ready_o,
    output logic      itlb_resp_valid_o,
    output tlb_resp_t itlb_resp_o,
    output logic      dtlb_resp_valid_o,
    output tlb_resp_t dtlb_resp_o,
    output logic      flush_done_o,
    output logic      mem_req_o,
    output paddr_t    mem_addr_o
);

    logic        lookup_valid;
    logic        lookup_ready;
    tlb_lookup_t lookup;
    logic        miss_valid;
    logic        miss_ready;
    tlb_lookup_t miss;
    logic        hit_valid;
    tlb_resp_t   hit;
    logic        walk_valid;
    logic        walk_ready;
    tlb_resp_t   walk;
    logic        refill_valid;

    // an accepted walker result doubles as the cache refill.
    assign refill_valid = walk_valid & walk_ready;

    l1_req_arbiter u_arbiter (
        .clk            (clk),
        .rst_i          (rst_i),
        .itlb_valid_i   (itlb_valid_i),
        .itlb_req_i     (itlb_req_i),
        .dtlb_valid_i   (dtlb_valid_i),
        .dtlb_req_i     (dtlb_req_i),
        .lookup_ready_i (lookup_ready),
        .refill_valid_i (refill_valid),
        .flush_i        (flush_i),
        .flush_done_i   (flush_done_o),
        .itlb_ready_o   (itlb_ready_o),
        .dtlb_ready_o   (dtlb_ready_o),
        .lookup_valid_o (lookup_valid),
        .lookup_o       (lookup)
    );

    tlb_cache u_cache (
        .clk            (clk),
        .rst_i          (rst_i),
        .lookup_valid_i (lookup_valid),
        .lookup_i       (lookup),
        .miss_ready_i   (miss_ready),
        .refill_valid_i (refill_valid),
        .refill_i       (walk),
        .flush_i        (flush_i),
        .lookup_ready_o (lookup_ready),
        .hit_valid_o    (hit_valid),
        .hit_o          (hit),
        .miss_valid_o   (miss_valid),
        .miss_o         (miss)
    );

    page_walker u_walker (
        .clk          (clk),
        .rst_i        (rst_i),
        .satp_ppn_i   (satp_ppn_i),
        .miss_valid_i (miss_valid),
        .miss_i       (miss),
        .walk_ready_i (walk_ready),
        .flush_i      (flush_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .miss_ready_o (miss_ready),
        .walk_valid_o (walk_valid),
        .walk_o       (walk),
        .flush_done_o (flush_done_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o)
    );

    resp_router u_router (
        .hit_valid_i  (hit_valid),
        .hit_i        (hit),
        .walk_valid_i (walk_valid),
        .walk_i       (walk),
        .walk_ready_o (walk_ready),
        .itlb_valid_o (itlb_resp_valid_o),
        .itlb_resp_o  (itlb_resp_o),
        .dtlb_valid_o (dtlb_resp_valid_o),
        .dtlb_resp_o  (dtlb_resp_o)
    );

endmodule

// ==== source/page_walker.sv ====
`timescale 1ns/10ps

module page_walker import sv32_pkg::*, tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  ppn_t        satp_ppn_i,
    input  logic        miss_valid_i,
    input  tlb_lookup_t miss_i,
    input  logic        walk_ready_i,
    input  logic        flush_i,
    input  logic        mem_rvalid_i,
    input  pte_t        mem_rdata_i,
    output logic        miss_ready_o,
    output logic        walk_valid_o,
    output tlb_resp_t   walk_o,
    output logic        flush_done_o,
    output logic        mem_req_o,
    output paddr_t      mem_addr_o
);

    typedef enum logic [2:0] {
        IDLE,
        L1_READ,
        L0_READ,
        RESULT,
        DRAIN,
        FLUSH_DONE
    } state_e;

    state_e      state_q;
    tlb_lookup_t req_q;
    tlb_resp_t   resp_q;
    paddr_t      addr_q;

    ppn_t       pte_ppn;
    pte_flags_t pte_flags;
    logic       pte_valid;
    logic       pte_leaf;
    logic       level1;
    logic       reading;
    logic       descend;
    vpn_part_t  vpn_lo;
    tlb_resp_t  leaf_resp;

    // entry address of a level is the table page plus index times entry size.
    function automatic paddr_t pte_addr(ppn_t base, vpn_part_t idx);
        return (paddr_t'(base) << PAGE_OFFSET_BITS) + paddr_t'(idx) * paddr_t'(PTE_BYTES);
    endfunction

    assign pte_ppn   = mem_rdata_i[PTE_PPN_LSB +: $bits(ppn_t)];
    assign pte_flags = mem_rdata_i[$bits(pte_flags_t)-1:0];
    assign pte_valid = pte_flags[PTE_V];
    assign pte_leaf  = pte_flags[PTE_R] | pte_flags[PTE_X];
    assign vpn_lo    = req_q.vpn[9:0];

    assign level1  = (state_q == L1_READ);
    assign reading = (state_q == L1_READ) | (state_q == L0_READ);
    // a valid pointer at level 1 leads on to level 0.
    assign descend = level1 & pte_valid & ~pte_leaf;

    always_comb begin
        leaf_resp     = '0;
        leaf_resp.vpn = req_q.vpn;
        leaf_resp.tag = req_q.tag;
        leaf_resp.src = req_q.src;
        if (!pte_valid || (!pte_leaf && !level1)
                || (pte_leaf && level1 && pte_ppn[9:0] != '0)) begin
            leaf_resp.fault = 1'b1;
        end else begin
            leaf_resp.flags     = pte_flags;
            leaf_resp.superpage = level1;
            leaf_resp.ppn       = level1 ? {pte_ppn[21:10], vpn_lo} : pte_ppn;
        end
    end

    // a flush in the accept cycle takes priority over the miss.
    assign miss_ready_o = (state_q == IDLE) & ~flush_i;
    assign walk_valid_o = (state_q == RESULT);
    assign walk_o       = resp_q;
    assign flush_done_o = (state_q == FLUSH_DONE);
    assign mem_req_o    = reading | (state_q == DRAIN);
    assign mem_addr_o   = addr_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (flush_i) begin
                        state_q <= FLUSH_DONE;
                    end else if (miss_valid_i) begin
                        state_q <= L1_READ;
                    end
                end
                L1_READ, L0_READ: begin
                    if (flush_i) begin
                        state_q <= mem_rvalid_i ? FLUSH_DONE : DRAIN;
                    end else if (mem_rvalid_i) begin
                        state_q <= descend ? L0_READ : RESULT;
                    end
                end
                RESULT: begin
                    if (flush_i) begin
                        state_q <= FLUSH_DONE;
                    end else if (walk_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                // wait out the read already on the bus.
                DRAIN: begin
                    if (mem_rvalid_i) begin
                        state_q <= FLUSH_DONE;
                    end
                end
                FLUSH_DONE: begin
                    if (!flush_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_valid_i && miss_ready_o) begin
            req_q  <= miss_i;
            addr_q <= pte_addr(satp_ppn_i, miss_i.vpn[19:10]);
        end
        if (reading && mem_rvalid_i) begin
            if (descend) begin
                addr_q <= pte_addr(pte_ppn, vpn_lo);
            end else begin
                resp_q <= leaf_resp;
            end
        end
    end

endmodule

// ==== source/resp_router.sv ====
`timescale 1ns/10ps

module resp_router import tlb_pkg::*; (
    input  logic      hit_valid_i,
    input  tlb_resp_t hit_i,
    input  logic      walk_valid_i,
    input  tlb_resp_t walk_i,
    output logic      walk_ready_o,
    output logic      itlb_valid_o,
    output tlb_resp_t itlb_resp_o,
    output logic      dtlb_valid_o,
    output tlb_resp_t dtlb_resp_o
);

    tlb_resp_t sel_resp;
    logic      sel_valid;

    // a cache hit cannot stall, so the walker waits a cycle.
    assign walk_ready_o = ~hit_valid_i;

    always_comb begin
        if (hit_valid_i) begin
            sel_resp  = hit_i;
            sel_valid = 1'b1;
        end else begin
            sel_resp  = walk_i;
            sel_valid = walk_valid_i;
        end
    end

    // steer by the port the request came from.
    assign itlb_valid_o = sel_valid & (sel_resp.src == SRC_ITLB);
    assign dtlb_valid_o = sel_valid & (sel_resp.src == SRC_DTLB);
    assign itlb_resp_o  = sel_resp;
    assign dtlb_resp_o  = sel_resp;

endmodule

// ==== source/sv32_pkg.sv ====
package sv32_pkg;

    // page geometry.
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int PTE_BYTES = 4;

    // flag positions inside a page-table entry.
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;

    // the ppn field starts right above the flags and the two rsw bits.
    localparam int PTE_PPN_LSB = 10;

    // virtual page number made of two 10 bit level indices.
    typedef logic [19:0] vpn_t;
    typedef logic [9:0]  vpn_part_t;

    // physical side.
    typedef logic [21:0] ppn_t;
    typedef logic [33:0] paddr_t;

    // raw entry as read from memory.
    typedef logic [31:0] pte_t;

    // V R W X U G A D with bit 0 first.
    typedef logic [7:0]  pte_flags_t;

endpackage

// ==== source/tlb_cache.sv ====
`timescale 1ns/10ps

module tlb_cache import sv32_pkg::*, tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        lookup_valid_i,
    input  tlb_lookup_t lookup_i,
    input  logic        miss_ready_i,
    input  logic        refill_valid_i,
    input  tlb_resp_t   refill_i,
    input  logic        flush_i,
    output logic        lookup_ready_o,
    output logic        hit_valid_o,
    output tlb_resp_t   hit_o,
    output logic        miss_valid_o,
    output tlb_lookup_t miss_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [TLB_ENTRIES-1:0] ent_valid_q;
    logic [TLB_ENTRIES-1:0] ent_super_q;
    vpn_t                   ent_vpn_q   [TLB_ENTRIES];
    ppn_t                   ent_ppn_q   [TLB_ENTRIES];
    pte_flags_t             ent_flags_q [TLB_ENTRIES];
    logic [TLB_IDX_BITS-1:0] victim_q;

    logic        stage_valid_q;
    tlb_lookup_t stage_q;
    logic        hit_valid_q;
    tlb_resp_t   hit_q;

    logic [TLB_ENTRIES-1:0]  stage_match;
    logic [TLB_ENTRIES-1:0]  refill_match;
    logic                    stage_hit;
    logic [TLB_IDX_BITS-1:0] hit_idx;
    logic                    refill_hit;
    logic [TLB_IDX_BITS-1:0] refill_idx;
    logic                    refill_we;
    logic                    stage_done;
    tlb_resp_t               hit_resp;

    // a superpage entry covers all 1024 pages under its upper index.
    function automatic logic entry_match(vpn_t ent_vpn, logic is_super, vpn_t vpn);
        return is_super ? (ent_vpn[19:10] == vpn[19:10]) : (ent_vpn == vpn);
    endfunction

    always_comb begin
        stage_hit  = 1'b0;
        hit_idx    = '0;
        refill_hit = 1'b0;
        refill_idx = victim_q;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            stage_match[i] = ent_valid_q[i]
                & entry_match(ent_vpn_q[i], ent_super_q[i], stage_q.vpn);
            refill_match[i] = ent_valid_q[i]
                & entry_match(ent_vpn_q[i], ent_super_q[i], refill_i.vpn);
            if (stage_match[i]) begin
                stage_hit = 1'b1;
                hit_idx   = TLB_IDX_BITS'(i);
            end
            if (refill_match[i]) begin
                refill_hit = 1'b1;
                refill_idx = TLB_IDX_BITS'(i);
            end
        end
    end

    always_comb begin
        hit_resp.vpn       = stage_q.vpn;
        hit_resp.tag       = stage_q.tag;
        hit_resp.src       = stage_q.src;
        hit_resp.flags     = ent_flags_q[hit_idx];
        hit_resp.superpage = ent_super_q[hit_idx];
        hit_resp.fault     = 1'b0;
        if (ent_super_q[hit_idx]) begin
            hit_resp.ppn = {ent_ppn_q[hit_idx][21:10], stage_q.vpn[9:0]};
        end else begin
            hit_resp.ppn = ent_ppn_q[hit_idx];
        end
    end

    // the stage frees on a hit or once the walker takes the miss.
    assign stage_done     = stage_valid_q & (stage_hit | miss_ready_i);
    assign lookup_ready_o = ~stage_valid_q | stage_done;

    assign miss_valid_o = stage_valid_q & ~stage_hit;
    assign miss_o       = stage_q;
    assign hit_valid_o  = hit_valid_q;
    assign hit_o        = hit_q;

    // faulting walks are never cached.
    assign refill_we = refill_valid_i & ~refill_i.fault;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            stage_valid_q <= 1'b0;
            hit_valid_q   <= 1'b0;
            ent_valid_q   <= '0;
            victim_q      <= '0;
        end else begin
            hit_valid_q <= stage_valid_q & stage_hit;
            if (lookup_valid_i && lookup_ready_o) begin
                stage_valid_q <= 1'b1;
            end else if (stage_done) begin
                stage_valid_q <= 1'b0;
            end
            if (refill_we) begin
                ent_valid_q[refill_idx] <= 1'b1;
                if (!refill_hit) begin
                    victim_q <= victim_q + 1'b1;
                end
            end
            // flush wins over a refill in the same cycle.
            if (flush_i) begin
                ent_valid_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid_i && lookup_ready_o) begin
            stage_q <= lookup_i;
        end
        hit_q <= hit_resp;
        if (refill_we) begin
            ent_vpn_q[refill_idx]   <= refill_i.vpn;
            ent_ppn_q[refill_idx]   <= refill_i.ppn;
            ent_flags_q[refill_idx] <= refill_i.flags;
            ent_super_q[refill_idx] <= refill_i.superpage;
        end
    end

endmodule

// ==== source/tlb_pkg.sv ====
package tlb_pkg;

    import sv32_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_BITS = $clog2(TLB_ENTRIES);

    // requester id that is echoed back with the response.
    typedef logic [2:0] tag_t;

    // origin port of a request.
    typedef logic src_t;
    localparam src_t SRC_ITLB = 1'b0;
    localparam src_t SRC_DTLB = 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transactions.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // request from one L1 port.
    typedef struct packed {
        vpn_t vpn;
        tag_t tag;
    } tlb_req_t;

    // request after arbitration tagged with its port.
    typedef struct packed {
        vpn_t vpn;
        tag_t tag;
        src_t src;
    } tlb_lookup_t;

    // translation result; ppn already holds the vpn low bits for superpages.
    typedef struct packed {
        vpn_t       vpn;
        ppn_t       ppn;
        pte_flags_t flags;
        logic       superpage;
        logic       fault;
        tag_t       tag;
        src_t       src;
    } tlb_resp_t;

endpackage
